//--- common/frontend_defs.svh
// front end width and reset defines

`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// machine word width
`define XLEN		32

// first fetch address after reset
`define RESET_PC	32'h0000_0100

// width of the event counters
`define CNT_W		16

`endif

//--- common/pipe_ctrl_pkg.sv
// front end control and stage payload types

package pipe_ctrl_pkg;

	// operand source for ID
	typedef enum logic [1:0] {
		RS_ID_SEL	= 2'd0,	// register file
		EX_ID_SEL	= 2'd1,
		MEM_ID_SEL	= 2'd2,
		WB_ID_SEL	= 2'd3
	} id_fwd_sel_t;

	typedef enum logic [1:0] {
		BOOT	= 2'd0,
		RUN		= 2'd1,
		STALL	= 2'd2,
		FLUSH	= 2'd3
	} fe_state_t;

	typedef struct packed {
		rv_isa_pkg::data_t	pc;
		rv_isa_pkg::instr_t	instr;
	} if_id_t;

	typedef struct packed {
		rv_isa_pkg::data_t	pc;
		rv_isa_pkg::instr_t	instr;
		rv_isa_pkg::data_t	link;	// pc + 4 for JAL / JALR writeback
		logic				taken;	// conditional branch outcome
	} id_ex_t;

endpackage : pipe_ctrl_pkg

//--- common/rv_isa_pkg.sv
// RV32I instruction encodings

`include "frontend_defs.svh"

package rv_isa_pkg;

	typedef logic [`XLEN-1:0] data_t;	// one machine word

	typedef logic [4:0] reg_addr_t;

	// major opcodes, only the ones the front end cares about are decoded
	typedef enum logic [6:0] {
		LOAD	= 7'b0000011,
		OP_IMM	= 7'b0010011,
		AUIPC	= 7'b0010111,
		STORE	= 7'b0100011,
		OP		= 7'b0110011,
		LUI		= 7'b0110111,
		B		= 7'b1100011,
		JALR	= 7'b1100111,
		JAL		= 7'b1101111,
		SYSTEM	= 7'b1110011
	} opcode_t;

	// branch conditions in funct3
	typedef enum logic [2:0] {
		BEQ		= 3'b000,
		BNE		= 3'b001,
		BLT		= 3'b100,
		BGE		= 3'b101,
		BLTU	= 3'b110,
		BGEU	= 3'b111
	} funct3_t;

	// R-type field layout, other formats reuse the same bit positions
	typedef struct packed {
		logic [6:0]	funct7;		// upper bits, also imm[11:5] / imm[12|10:5]
		reg_addr_t	rs2;
		reg_addr_t	rs1;
		funct3_t	funct3;
		reg_addr_t	rd;
		opcode_t	opcode;
	} instr_t;

endpackage : rv_isa_pkg

//--- design/cf_event_counters.sv
// front end event counters

`timescale 1ns/10ps
`include "frontend_defs.svh"

module cf_event_counters (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				id_fire,
	input	logic				redirect,
	input	logic				id_stall,

	output	logic [`CNT_W-1:0]	cnt_decoded,
	output	logic [`CNT_W-1:0]	cnt_redirect,
	output	logic [`CNT_W-1:0]	cnt_stall
);

	logic [2:0]			ev;
	logic [`CNT_W-1:0]	cnt [3];

	assign ev = {id_stall, redirect, id_fire};

	// one saturating counter per event bit
	for (genvar i = 0; i < 3; i++) begin : g_cnt
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n)
				cnt[i] <= '0;
			else if (ev[i] && cnt[i] != '1)
				cnt[i] <= cnt[i] + 1'b1;
		end
	end

	assign cnt_decoded	= cnt[0];
	assign cnt_redirect	= cnt[1];
	assign cnt_stall	= cnt[2];

endmodule : cf_event_counters

//--- design/frontend_top.sv
// RV32I instruction front end

`timescale 1ns/10ps
`include "frontend_defs.svh"

module frontend_top (
	input	logic					clk,
	input	logic					rst_n,
	output	rv_isa_pkg::data_t		imem_addr,
	input	rv_isa_pkg::instr_t		imem_rdata,
	output	rv_isa_pkg::reg_addr_t	rs1_addr,
	output	rv_isa_pkg::reg_addr_t	rs2_addr,
	input	rv_isa_pkg::data_t		rs1_data,
	input	rv_isa_pkg::data_t		rs2_data,
	input	rv_isa_pkg::reg_addr_t	ex_rd,
	input	logic					ex_wen,
	input	logic					ex_load,
	input	rv_isa_pkg::data_t		ex_data,
	input	rv_isa_pkg::reg_addr_t	mem_rd,
	input	logic					mem_wen,
	input	logic					mem_load,
	input	rv_isa_pkg::data_t		mem_data,
	input	rv_isa_pkg::reg_addr_t	wb_rd,
	input	logic					wb_wen,
	input	rv_isa_pkg::data_t		wb_data,
	output	logic					ex_valid,
	output	rv_isa_pkg::data_t		ex_pc,
	output	rv_isa_pkg::instr_t		ex_instr,
	output	rv_isa_pkg::data_t		ex_link,
	output	logic					ex_taken,
	output	logic					redirect,
	output	rv_isa_pkg::data_t		redirect_pc,
	output	logic					id_stall,
	output	logic [`CNT_W-1:0]		cnt_decoded,
	output	logic [`CNT_W-1:0]		cnt_redirect,
	output	logic [`CNT_W-1:0]		cnt_stall
);

	rv_isa_pkg::data_t			pc;
	rv_isa_pkg::data_t			pc_bj;
	logic						fetch_en;
	logic						if_flush;
	logic						stall_req;
	logic						pc_sel;
	logic						branch_taken;
	logic						id_valid;
	logic						id_fire;
	pipe_ctrl_pkg::if_id_t		if_in;
	pipe_ctrl_pkg::if_id_t		id_q;
	pipe_ctrl_pkg::id_ex_t		ex_in;
	pipe_ctrl_pkg::id_ex_t		ex_q;
	pipe_ctrl_pkg::id_fwd_sel_t	fwd_rs1;
	pipe_ctrl_pkg::id_fwd_sel_t	fwd_rs2;

	assign imem_addr	= pc;
	assign if_in		= '{pc: pc, instr: imem_rdata};
	assign rs1_addr		= id_q.instr.rs1;
	assign rs2_addr		= id_q.instr.rs2;
	assign id_fire		= id_valid & ~id_stall;

	fetch_ctrl u_fetch_ctrl (
		.clk, .rst_n, .id_valid, .stall_req, .pc_sel, .pc_bj,
		.pc, .fetch_en, .if_flush, .id_stall, .redirect, .state()
	);

	pipe_stage #(.payload_t(pipe_ctrl_pkg::if_id_t)) u_if_id (
		.clk, .rst_n, .load(~id_stall), .flush(if_flush),
		.in_valid(fetch_en), .in_data(if_in), .out_valid(id_valid), .out_data(id_q)
	);

	id_forward_unit u_id_forward_unit (
		.instr(id_q.instr), .id_valid, .ex_rd, .mem_rd, .wb_rd,
		.ex_wen, .mem_wen, .wb_wen, .ex_load, .mem_load, .fwd_rs1, .fwd_rs2, .stall_req
	);

	// pc_nxt equals pc_bj whenever redirect is high
	pc_adder u_pc_adder (
		.instr(id_q.instr), .pc(id_q.pc), .rs1(rs1_data), .rs2(rs2_data),
		.ex_data, .mem_data, .wb_data, .fwd_rs1, .fwd_rs2,
		.pc_bj, .pc_nxt(redirect_pc), .pc_sel, .branch_taken
	);

	assign ex_in = '{pc: id_q.pc, instr: id_q.instr,
					 link: id_q.pc + rv_isa_pkg::data_t'(4), taken: branch_taken};

	// a stalled ID slot goes to EX as a bubble
	pipe_stage #(.payload_t(pipe_ctrl_pkg::id_ex_t)) u_id_ex (
		.clk, .rst_n, .load(1'b1), .flush(id_stall),
		.in_valid(id_valid), .in_data(ex_in), .out_valid(ex_valid), .out_data(ex_q)
	);

	assign ex_pc	= ex_q.pc;
	assign ex_instr	= ex_q.instr;
	assign ex_link	= ex_q.link;
	assign ex_taken	= ex_q.taken;

	cf_event_counters u_cf_event_counters (
		.clk, .rst_n, .id_fire, .redirect, .id_stall,
		.cnt_decoded, .cnt_redirect, .cnt_stall
	);

endmodule : frontend_top

//--- design/pipe_stage.sv
// valid tagged pipeline register

`timescale 1ns/10ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input	logic		clk,
	input	logic		rst_n,
	input	logic		load,
	input	logic		flush,
	input	logic		in_valid,
	input	payload_t	in_data,

	output	logic		out_valid,
	output	payload_t	out_data
);

	// flush has priority over load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (flush)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (load)
			out_data <= in_data;	// qualified by out_valid downstream
	end

endmodule : pipe_stage

//--- dv/frontend_properties.sv
// fetch control assertions

`timescale 1ns/10ps

module frontend_properties (
	input	logic						clk,
	input	logic						rst_n,
	input	logic						id_valid,
	input	logic						redirect,
	input	logic						id_stall,
	input	pipe_ctrl_pkg::fe_state_t	state,
	input	rv_isa_pkg::data_t			pc,
	input	rv_isa_pkg::data_t			pc_bj
);

	a_no_redirect_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!(redirect && id_stall))
		else $error("redirect and id_stall high in the same cycle");

	// the wrong-path IF/ID entry is gone in FLUSH
	a_flush_after_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |=> state == pipe_ctrl_pkg::FLUSH && !id_valid)
		else $error("redirect not followed by FLUSH with an empty ID stage");

	// flush bubble is exactly one cycle
	a_flush_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		state == pipe_ctrl_pkg::FLUSH |=> state != pipe_ctrl_pkg::FLUSH && id_valid)
		else $error("ID bubble after FLUSH lasted more than one cycle");

	a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
		pc != $past(pc) |-> (pc == $past(pc) + 32'd4) || (pc == $past(pc_bj)))
		else $error("PC moved to neither pc+4 nor the branch target");

endmodule : frontend_properties

//--- dv/frontend_tb.sv
// front end testbench

`timescale 1ns/10ps
`include "frontend_defs.svh"

module frontend_tb;

	localparam int PHASE_CYCLES = 400;	// five phases
	localparam int MAX_CYCLES = 2 * 5 * PHASE_CYCLES;	// twice the test length
	localparam int BOOT_IDX = (`RESET_PC >> 2) & 1023;	// imem slot of the reset PC

	logic					clk;
	logic					rst_n;
	rv_isa_pkg::data_t		imem_addr;
	rv_isa_pkg::instr_t		imem_rdata;
	rv_isa_pkg::reg_addr_t	rs1_addr;
	rv_isa_pkg::reg_addr_t	rs2_addr;
	rv_isa_pkg::data_t		rs1_data;
	rv_isa_pkg::data_t		rs2_data;
	rv_isa_pkg::reg_addr_t	ex_rd;
	rv_isa_pkg::reg_addr_t	mem_rd;
	rv_isa_pkg::reg_addr_t	wb_rd;
	logic					ex_wen;
	logic					mem_wen;
	logic					wb_wen;
	logic					ex_load;
	logic					mem_load;
	rv_isa_pkg::data_t		ex_data;
	rv_isa_pkg::data_t		mem_data;
	rv_isa_pkg::data_t		wb_data;
	logic					ex_valid;
	rv_isa_pkg::data_t		ex_pc;
	rv_isa_pkg::instr_t		ex_instr;
	rv_isa_pkg::data_t		ex_link;
	logic					ex_taken;
	logic					redirect;
	rv_isa_pkg::data_t		redirect_pc;
	logic					id_stall;
	logic [`CNT_W-1:0]		cnt_decoded;
	logic [`CNT_W-1:0]		cnt_redirect;
	logic [`CNT_W-1:0]		cnt_stall;

	logic [31:0]	imem [1024];	// program image, aliased over the address space
	logic [31:0]	regs [32];
	logic [31:0]	f_pc;		// expected fetch PC
	logic [31:0]	id_pc;
	logic			id_v;
	logic			booted;
	logic			exp_v;
	logic [31:0]	exp_pc;
	logic [31:0]	exp_instr;
	logic			exp_taken;
	logic			done_req;
	int				cycles;
	int				n_decoded;
	int				n_redirect;
	int				n_stall;

	assign imem_rdata = imem[imem_addr[11:2]];
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	frontend_top dut (.*);

	bind fetch_ctrl frontend_properties u_props (
		.clk, .rst_n, .id_valid, .redirect, .id_stall, .state, .pc, .pc_bj
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// youngest writer first, x0 always reads the register file
	function automatic logic [31:0] fwd_ref(input logic [4:0] rs);
		if (rs != 5'd0 && ex_wen && ex_rd == rs)
			return ex_data;
		if (rs != 5'd0 && mem_wen && mem_rd == rs)
			return mem_data;
		if (rs != 5'd0 && wb_wen && wb_rd == rs)
			return wb_data;
		return regs[rs];
	endfunction

	function automatic logic load_wait(input logic [4:0] rs);
		if (rs == 5'd0)
			return 1'b0;
		if (ex_wen && ex_rd == rs)
			return ex_load;
		if (mem_wen && mem_rd == rs)
			return mem_load;
		return 1'b0;
	endfunction

	function automatic logic stall_ref(input logic [31:0] ins);
		if (ins[6:0] == 7'b1100011)
			return load_wait(ins[19:15]) || load_wait(ins[24:20]);
		return ins[6:0] == 7'b1100111 && load_wait(ins[19:15]);
	endfunction

	function automatic void resolve_ref(input logic [31:0] ins, input logic [31:0] pc,
			output logic taken, output logic [31:0] target, output logic [31:0] nxt);
		logic [31:0] a;
		logic [31:0] b;
		a = fwd_ref(ins[19:15]);
		b = fwd_ref(ins[24:20]);
		taken = 1'b0;
		target = pc + 32'd4;
		case (ins[6:0])
			7'b1100011: begin
				case (ins[14:12])
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					3'b111: taken = (a >= b);
					default: taken = 1'b0;
				endcase
				target = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			7'b1101111: begin
				taken = 1'b1;
				target = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			7'b1100111: begin
				taken = 1'b1;
				target = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
			end
			default: ;
		endcase
		nxt = taken ? target : pc + 32'd4;
	endfunction

	// regs x0..x7 only, so stage rd values hit often
	task automatic load_program();
		logic [31:0]	r;
		logic [2:0]		f3;
		logic [4:0]		ra;
		logic [4:0]		rb;
		for (int i = 0; i < 1024; i++) begin
			// straight-line code right after the reset PC
			r = (i >= BOOT_IDX && i < BOOT_IDX + 16) ? 32'd0 : $urandom % 10;
			ra = 5'($urandom % 8);
			rb = 5'($urandom % 8);
			f3 = 3'($urandom % 6);
			f3 = (f3 < 3'd2) ? f3 : f3 + 3'd2;	// skip reserved 010 / 011
			if (r >= 4 && r <= 6)
				imem[i] = {imem_b_off(), rb, ra, f3, 5'd0, 7'b1100011} | imem_b_imm();
			else if (r == 7)
				imem[i] = {jal_imm(), ra, 7'b1101111};
			else if (r == 8)
				imem[i] = {12'($urandom), rb, 3'b000, ra, 7'b1100111};
			else
				imem[i] = {12'($urandom % 64), rb, 3'b000, ra, 7'b0010011};
		end
	endtask

	// B offset bits in the upper field, a multiple of 4 within +-32 bytes
	function automatic logic [6:0] imem_b_off();
		logic [12:0] off;
		off = 13'(($urandom % 16) * 4) - 13'd32;
		return {off[12], off[10:5]};
	endfunction

	function automatic logic [31:0] imem_b_imm();
		logic [12:0] off;
		off = 13'(($urandom % 16) * 4) - 13'd32;
		return {20'd0, off[4:1], off[11], 7'd0};
	endfunction

	function automatic logic [19:0] jal_imm();
		logic [20:0] off;
		off = 21'(($urandom % 128) * 4) - 21'd256;
		return {off[20], off[10:1], off[11], off[19:12]};
	endfunction

	function automatic logic [31:0] boundary_val();
		case ($urandom % 6)
			0: return 32'h0000_0000;
			1: return 32'h0000_0001;
			2: return 32'hffff_ffff;
			3: return 32'h7fff_ffff;
			4: return 32'h8000_0000;
			default: return $urandom;
		endcase
	endfunction

	task automatic drive_stage(input int p);
		logic [31:0] v;
		v = boundary_val();
		if (p == 1 || p == 4) begin
			regs[1 + $urandom % 7] <= v;
			if ($urandom % 2 == 0)
				regs[1 + $urandom % 7] <= v;	// equal operand pairs
		end
		if (p >= 2 && $urandom % 3 == 0) begin	// levels held a few cycles
			ex_rd <= 5'($urandom % 8);
			mem_rd <= 5'($urandom % 8);
			wb_rd <= 5'($urandom % 8);
			ex_wen <= 1'($urandom);
			mem_wen <= 1'($urandom);
			wb_wen <= 1'($urandom);
			ex_load <= (p >= 3) && ($urandom % 2 == 0);
			mem_load <= (p >= 3) && ($urandom % 2 == 0);
			ex_data <= boundary_val();
			mem_data <= boundary_val();
			wb_data <= boundary_val();
		end
	endtask

	initial begin : main
		void'($urandom(70));
		rst_n = 1'b0;
		{ex_rd, mem_rd, wb_rd} = '0;
		{ex_wen, mem_wen, wb_wen, ex_load, mem_load} = '0;
		{ex_data, mem_data, wb_data} = '0;
		done_req = 1'b0;
		for (int k = 0; k < 32; k++)
			regs[k] = (k == 0) ? 32'd0 : $urandom;
		load_program();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (int p = 0; p < 5; p++) begin
			for (int c = 0; c < PHASE_CYCLES; c++) begin
				@(posedge clk);
				drive_stage(p);
			end
		end
		@(posedge clk);
		done_req <= 1'b1;
	end

	initial begin
		{f_pc, id_pc} = {`RESET_PC, `RESET_PC};
		{id_v, booted, exp_v} = '0;
		{exp_pc, exp_instr, exp_taken} = '0;
		{cycles, n_decoded, n_redirect, n_stall} = '0;
	end

	always @(posedge clk) begin : timeout
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin : compare
		logic [31:0]	ins;
		logic [31:0]	target;
		logic [31:0]	nxt;
		logic			taken;
		logic			stall;
		logic			cf;
		if (rst_n && done_req) begin
			check_val("cnt_decoded", 32'(cnt_decoded), n_decoded);
			check_val("cnt_redirect", 32'(cnt_redirect), n_redirect);
			check_val("cnt_stall", 32'(cnt_stall), n_stall);
			$display("TEST RESULT: PASS");
			$finish;
		end else if (rst_n) begin
			check_val("ex_valid", 32'(ex_valid), 32'(exp_v));
			if (exp_v) begin
				check_val("ex_pc", ex_pc, exp_pc);
				check_val("ex_instr", ex_instr, exp_instr);
				check_val("ex_link", ex_link, exp_pc + 32'd4);
				check_val("ex_taken", 32'(ex_taken), 32'(exp_taken));
			end
			check_val("imem_addr", imem_addr, f_pc);
			ins = imem[id_pc[11:2]];
			resolve_ref(ins, id_pc, taken, target, nxt);
			stall = id_v && stall_ref(ins);
			cf = id_v && taken && !stall;
			check_val("id_stall", 32'(id_stall), 32'(stall));
			check_val("redirect", 32'(redirect), 32'(cf));
			if (cf)
				check_val("redirect_pc", redirect_pc, nxt);
			exp_v = id_v && !stall;
			exp_pc = id_pc;
			exp_instr = ins;
			exp_taken = (ins[6:0] == 7'b1100011) && taken;
			n_decoded += int'(exp_v);
			n_redirect += int'(cf);
			n_stall += int'(stall);
			if (cf) begin
				id_v = 1'b0;	// wrong-path word dropped
				f_pc = target;
			end else if (!stall) begin
				id_v = booted;
				id_pc = f_pc;
				f_pc = booted ? f_pc + 32'd4 : f_pc;
				booted = 1'b1;
			end
		end
	end

endmodule : frontend_tb

//--- filelist.f
+incdir+common
common/rv_isa_pkg.sv
common/pipe_ctrl_pkg.sv
frontend/pc_adder.sv
frontend/id_forward_unit.sv
frontend/fetch_ctrl.sv
design/pipe_stage.sv
design/cf_event_counters.sv
design/frontend_top.sv
dv/frontend_properties.sv
dv/frontend_tb.sv

//--- frontend/fetch_ctrl.sv
// fetch PC and front end control FSM

`timescale 1ns/10ps
`include "frontend_defs.svh"

module fetch_ctrl (
	input	logic						clk,
	input	logic						rst_n,
	input	logic						id_valid,
	input	logic						stall_req,
	input	logic						pc_sel,
	input	rv_isa_pkg::data_t			pc_bj,

	output	rv_isa_pkg::data_t			pc,
	output	logic						fetch_en,
	output	logic						if_flush,
	output	logic						id_stall,
	output	logic						redirect,
	output	pipe_ctrl_pkg::fe_state_t	state
);

	pipe_ctrl_pkg::fe_state_t	state_nxt;

	assign fetch_en	= (state != pipe_ctrl_pkg::BOOT);
	assign id_stall	= id_valid & stall_req;
	assign redirect	= id_valid & pc_sel & ~stall_req;	// operands must be final
	assign if_flush	= redirect;	// drop the wrong-path word being fetched now

	always_comb begin
		state_nxt = state;
		case (state)
			pipe_ctrl_pkg::BOOT:
				state_nxt = pipe_ctrl_pkg::RUN;
			pipe_ctrl_pkg::RUN,
			pipe_ctrl_pkg::STALL: begin
				if (redirect)
					state_nxt = pipe_ctrl_pkg::FLUSH;
				else if (id_stall)
					state_nxt = pipe_ctrl_pkg::STALL;
				else
					state_nxt = pipe_ctrl_pkg::RUN;
			end
			pipe_ctrl_pkg::FLUSH:
				state_nxt = pipe_ctrl_pkg::RUN;	// ID bubble lasts one cycle
			default:
				state_nxt = pipe_ctrl_pkg::BOOT;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= pipe_ctrl_pkg::BOOT;
		else
			state <= state_nxt;
	end

	// pc register, held in BOOT and while ID waits on a load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= pc_bj;
		end else if (fetch_en && !id_stall) begin
			pc <= pc + rv_isa_pkg::data_t'(4);
		end
	end

endmodule : fetch_ctrl

//--- frontend/id_forward_unit.sv
// ID operand forwarding and load-use stall

`timescale 1ns/10ps

module id_forward_unit (
	input	rv_isa_pkg::instr_t			instr,
	input	logic						id_valid,
	input	rv_isa_pkg::reg_addr_t		ex_rd,
	input	rv_isa_pkg::reg_addr_t		mem_rd,
	input	rv_isa_pkg::reg_addr_t		wb_rd,
	input	logic						ex_wen,
	input	logic						mem_wen,
	input	logic						wb_wen,
	input	logic						ex_load,
	input	logic						mem_load,

	output	pipe_ctrl_pkg::id_fwd_sel_t	fwd_rs1,
	output	pipe_ctrl_pkg::id_fwd_sel_t	fwd_rs2,
	output	logic						stall_req
);

	logic	is_b;
	logic	is_jalr;
	logic	rs1_wait;
	logic	rs2_wait;

	// youngest writer wins, x0 is never forwarded
	function automatic pipe_ctrl_pkg::id_fwd_sel_t pick_src(input rv_isa_pkg::reg_addr_t rs);
		if (rs == '0)
			return pipe_ctrl_pkg::RS_ID_SEL;
		if (ex_wen && ex_rd == rs)
			return pipe_ctrl_pkg::EX_ID_SEL;
		if (mem_wen && mem_rd == rs)
			return pipe_ctrl_pkg::MEM_ID_SEL;
		if (wb_wen && wb_rd == rs)
			return pipe_ctrl_pkg::WB_ID_SEL;
		return pipe_ctrl_pkg::RS_ID_SEL;
	endfunction

	always_comb begin
		fwd_rs1 = pick_src(instr.rs1);
		fwd_rs2 = pick_src(instr.rs2);
	end

	assign is_b		= (instr.opcode == rv_isa_pkg::B);
	assign is_jalr	= (instr.opcode == rv_isa_pkg::JALR);

	// load data shows up after MEM, so EX and MEM loads cannot feed ID yet
	assign rs1_wait = (fwd_rs1 == pipe_ctrl_pkg::EX_ID_SEL && ex_load) ||
					  (fwd_rs1 == pipe_ctrl_pkg::MEM_ID_SEL && mem_load);
	assign rs2_wait = (fwd_rs2 == pipe_ctrl_pkg::EX_ID_SEL && ex_load) ||
					  (fwd_rs2 == pipe_ctrl_pkg::MEM_ID_SEL && mem_load);

	assign stall_req = id_valid & ((is_b & (rs1_wait | rs2_wait)) | (is_jalr & rs1_wait));

endmodule : id_forward_unit

//--- frontend/pc_adder.sv
// ID stage branch and jump resolution

`timescale 1ns/10ps
`include "frontend_defs.svh"

module pc_adder (
	input	rv_isa_pkg::instr_t			instr,
	input	rv_isa_pkg::data_t			pc,
	input	rv_isa_pkg::data_t			rs1,
	input	rv_isa_pkg::data_t			rs2,
	input	rv_isa_pkg::data_t			ex_data,
	input	rv_isa_pkg::data_t			mem_data,
	input	rv_isa_pkg::data_t			wb_data,
	input	pipe_ctrl_pkg::id_fwd_sel_t	fwd_rs1,
	input	pipe_ctrl_pkg::id_fwd_sel_t	fwd_rs2,

	output	rv_isa_pkg::data_t			pc_bj,
	output	rv_isa_pkg::data_t			pc_nxt,
	output	logic						pc_sel,
	output	logic						branch_taken
);

	rv_isa_pkg::opcode_t	opcode;
	rv_isa_pkg::funct3_t	funct3;
	rv_isa_pkg::data_t		op1;
	rv_isa_pkg::data_t		op2;
	rv_isa_pkg::data_t		imm;
	rv_isa_pkg::data_t		base;
	rv_isa_pkg::data_t		sum;
	logic					is_b;
	logic					is_jal;
	logic					is_jalr;
	logic					eq;
	logic					lt_s;
	logic					lt_u;
	logic					cond;

	function automatic rv_isa_pkg::data_t pick_op(
		input pipe_ctrl_pkg::id_fwd_sel_t	sel,
		input rv_isa_pkg::data_t			rf_val
	);
		case (sel)
			pipe_ctrl_pkg::EX_ID_SEL:	return ex_data;
			pipe_ctrl_pkg::MEM_ID_SEL:	return mem_data;
			pipe_ctrl_pkg::WB_ID_SEL:	return wb_data;
			default:					return rf_val;
		endcase
	endfunction

	assign opcode	= instr.opcode;
	assign funct3	= instr.funct3;
	assign is_b		= (opcode == rv_isa_pkg::B);
	assign is_jal	= (opcode == rv_isa_pkg::JAL);
	assign is_jalr	= (opcode == rv_isa_pkg::JALR);

	always_comb begin : operand_mux
		op1 = pick_op(fwd_rs1, rs1);
		op2 = pick_op(fwd_rs2, rs2);
	end

	assign eq	= (op1 == op2);
	assign lt_s	= ($signed(op1) < $signed(op2));
	assign lt_u	= (op1 < op2);

	always_comb begin
		case (funct3)
			rv_isa_pkg::BEQ:	cond = eq;
			rv_isa_pkg::BNE:	cond = ~eq;
			rv_isa_pkg::BLT:	cond = lt_s;
			rv_isa_pkg::BGE:	cond = ~lt_s;
			rv_isa_pkg::BLTU:	cond = lt_u;
			rv_isa_pkg::BGEU:	cond = ~lt_u;
			default:			cond = 1'b0;	// 010 / 011 are reserved
		endcase
	end

	assign branch_taken = is_b & cond;

	// B and J offsets are in halfwords, JALR uses the plain I immediate
	always_comb begin
		case (opcode)
			rv_isa_pkg::B:		imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			rv_isa_pkg::JAL:	imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			rv_isa_pkg::JALR:	imm = {{20{instr[31]}}, instr[31:20]};
			default:			imm = '0;
		endcase
	end

	assign base = is_jalr ? op1 : pc;	// JALR is register relative
	assign sum = base + imm;
	assign pc_bj = is_jalr ? {sum[`XLEN-1:1], 1'b0} : sum;

	assign pc_sel = branch_taken | is_jal | is_jalr;
	assign pc_nxt = pc_sel ? pc_bj : pc + rv_isa_pkg::data_t'(4);

endmodule : pc_adder

//--- run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module frontend_tb \
	-o sim_frontend > build.log 2>&1 \
	&& ./obj_dir/sim_frontend > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
